// File: project.f
logic/window_types_pkg.sv
logic/monitor_ctrl_pkg.sv
logic/window_compare.sv
logic/dwell_timer.sv
logic/crossing_fsm.sv
logic/event_counter.sv
logic/window_monitor.sv
test/window_monitor_model.sv
test/window_monitor_tb.sv

// File: Bender.yml
package:
  name: window_monitor

sources:
  - logic/window_types_pkg.sv
  - logic/monitor_ctrl_pkg.sv
  - logic/window_compare.sv
  - logic/dwell_timer.sv
  - logic/crossing_fsm.sv
  - logic/event_counter.sv
  - logic/window_monitor.sv
  - target: test
    files:
      - test/window_monitor_model.sv
      - test/window_monitor_tb.sv

// File: test/window_monitor_tb.sv
// testbench for the window monitor, random stimulus checked cycle by cycle against the model
module window_monitor_tb;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int t1_len    = 40;
    localparam int t2_len    = 200;
    localparam int t3_len    = 24 + 12 * 44;
    localparam int t4_len    = 7 * 7 * 3;
    localparam int t5_len    = 585;
    localparam int run_limit = 16 + t1_len + t2_len + t3_len + t4_len + t5_len + 100;

    logic                         clk = 1'b0;
    logic                         rst_n;
    window_types_pkg::sample_t    data_in;
    window_types_pkg::sample_t    win_low;
    window_types_pkg::sample_t    win_high;
    window_types_pkg::dwell_t     dwell_len;
    logic                         count_clear;
    logic                         cross_event;
    monitor_ctrl_pkg::cross_dir_t cross_dir;
    window_types_pkg::side_t      cross_side;
    logic                         outside;
    window_types_pkg::count_t     exit_count;
    window_types_pkg::count_t     entry_count;
    logic                         exp_event;
    monitor_ctrl_pkg::cross_dir_t exp_dir;
    window_types_pkg::side_t      exp_side;
    logic                         exp_outside;
    window_types_pkg::count_t     exp_exit_count;
    window_types_pkg::count_t     exp_entry_count;

    integer seed;
    int     errors = 0;
    int     errors_at_start = 0;
    int     tests_passed = 0;
    int     tests_failed = 0;
    int     events_seen;
    int     cycles = 0;
    int     lo;
    int     hi;
    int     dwell;
    int     len;
    int     corner_low  [7] = '{0, 0, 255, 1, 200, 255, 128};
    int     corner_high [7] = '{255, 0, 255, 254, 50, 0, 127};
    int     corner_data [6] = '{0, 1, 127, 128, 254, 255};

    always #50 clk = ~clk;

    window_monitor window_monitor_i (
        .clk (clk), .rst_n (rst_n), .data_in (data_in), .win_low (win_low),
        .win_high (win_high), .dwell_len (dwell_len), .count_clear (count_clear),
        .cross_event (cross_event), .cross_dir (cross_dir), .cross_side (cross_side),
        .outside (outside), .exit_count (exit_count), .entry_count (entry_count)
    );

    monitor_model monitor_model_i (
        .clk (clk), .rst_n (rst_n), .data_in (data_in), .win_low (win_low),
        .win_high (win_high), .dwell_len (dwell_len), .count_clear (count_clear),
        .exp_event (exp_event), .exp_dir (exp_dir), .exp_side (exp_side),
        .exp_outside (exp_outside), .exp_exit_count (exp_exit_count),
        .exp_entry_count (exp_entry_count)
    );

    always @(posedge clk) begin
        cycles++;
        if (cycles > run_limit) begin
            $display("timeout: run did not finish");
            $display("TEST FAILED");
            $finish;
        end
    end

    task automatic check_bit(input string name, input logic expected, input logic actual);
        if (actual !== expected) begin
            errors++;
            $display("error %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_side(input string name, input window_types_pkg::side_t expected,
                              input window_types_pkg::side_t actual);
        if (actual !== expected) begin
            errors++;
            $display("error %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_dir(input string name, input monitor_ctrl_pkg::cross_dir_t expected,
                             input monitor_ctrl_pkg::cross_dir_t actual);
        if (actual !== expected) begin
            errors++;
            $display("error %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    task automatic check_count(input string name, input window_types_pkg::count_t expected,
                               input window_types_pkg::count_t actual);
        if (actual !== expected) begin
            errors++;
            $display("error %s expected 0x%0h actual 0x%0h at %0t", name, expected, actual, $time);
        end
    endtask

    function automatic int rand_between(input int low, input int high);
        int r;
        r = $random(seed);
        return low + (r & 32'h7fff_ffff) % (high - low + 1);
    endfunction

    // a sample below or above the window, picked at random when both exist
    function automatic int rand_outside(input int low, input int high);
        int r;
        r = $random(seed);
        if ((r[0] && low > 0) || high >= 255) begin
            return rand_between(0, low - 1);
        end
        return rand_between(high + 1, 255);
    endfunction

    // compare all outputs at the falling edge, then apply the next sample
    task automatic drive_sample(input int value, input int low, input int high, input logic clear);
        @(negedge clk);
        check_bit("cross_event", exp_event, cross_event);
        check_dir("cross_dir", exp_dir, cross_dir);
        check_side("cross_side", exp_side, cross_side);
        check_bit("outside", exp_outside, outside);
        check_count("exit_count", exp_exit_count, exit_count);
        check_count("entry_count", exp_entry_count, entry_count);
        if (cross_event) begin
            events_seen++;
        end
        data_in     = window_types_pkg::sample_t'(value);
        win_low     = window_types_pkg::sample_t'(low);
        win_high    = window_types_pkg::sample_t'(high);
        count_clear = clear;
    endtask

    task automatic finish_test(input string name);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %s: ok", name);
        end else begin
            tests_failed++;
            $display("test %s: %0d errors", name, errors - errors_at_start);
        end
        errors_at_start = errors;
    endtask

    initial begin
        seed        = 32'hcc40_5f0d;
        rst_n       = 1'b0;
        data_in     = '0;
        win_low     = '0;
        win_high    = '0;
        dwell_len   = '0;
        count_clear = 1'b0;
        repeat (16) @(posedge clk);
        @(negedge clk);
        check_bit("cross_event", 1'b0, cross_event);
        check_dir("cross_dir", monitor_ctrl_pkg::dir_exit, cross_dir);
        check_side("cross_side", window_types_pkg::side_low, cross_side);
        check_bit("outside", 1'b0, outside);
        check_count("exit_count", '0, exit_count);
        check_count("entry_count", '0, entry_count);
        rst_n = 1'b1;

        events_seen = 0;
        for (int i = 0; i < t1_len; i++) begin
            drive_sample(rand_between(10, 240), 10, 240, 1'b0);
        end
        if (events_seen != 0) begin
            errors++;
            $display("crossing event seen while every sample stayed inside the window");
        end
        finish_test("reset and steady inside");

        // dwell 0, every change of classification is an event
        lo = rand_between(40, 120);
        hi = lo + rand_between(20, 80);
        for (int i = 0; i < t2_len; i++) begin
            drive_sample(rand_between(lo - 20, hi + 20), lo, hi, 1'b0);
        end
        finish_test("dwell zero");

        dwell     = rand_between(1, 15);
        dwell_len = window_types_pkg::dwell_t'(dwell);
        lo        = rand_between(16, 100);
        hi        = lo + rand_between(16, 100);
        for (int i = 0; i < 24; i++) begin
            drive_sample(rand_between(lo, hi), lo, hi, 1'b0);
        end
        for (int round = 0; round < 12; round++) begin
            len = (round % 2 == 0) ? rand_between(1, dwell) : dwell + rand_between(1, 6);
            events_seen = 0;
            for (int i = 0; i < len; i++) begin
                drive_sample(rand_outside(lo, hi), lo, hi, 1'b0);
            end
            for (int i = 0; i < dwell + 8; i++) begin
                drive_sample(rand_between(lo, hi), lo, hi, 1'b0);
            end
            if (events_seen != ((len > dwell) ? 2 : 0)) begin
                errors++;
                $display("%0d events after an excursion of %0d samples with dwell %0d",
                         events_seen, len, dwell);
            end
        end
        finish_test("dwell filter");

        // each corner sample is followed by two samples inside a full-range window
        dwell_len = '0;
        for (int w = 0; w < 7; w++) begin
            for (int j = 0; j < 7; j++) begin
                drive_sample((j < 6) ? corner_data[j] : rand_between(0, 255),
                             corner_low[w], corner_high[w], 1'b0);
                drive_sample(128, 0, 255, 1'b0);
                drive_sample(128, 0, 255, 1'b0);
            end
        end
        finish_test("full range and inverted windows");

        // alternating samples give one event per cycle, enough to saturate both counts
        for (int i = 0; i < t5_len; i++) begin
            drive_sample((i % 2 == 0) ? rand_outside(100, 150) : rand_between(100, 150),
                         100, 150, i == 546);
            if (i == 545) begin
                check_count("exit_count", '1, exit_count);
                check_count("entry_count", '1, entry_count);
            end
        end
        finish_test("saturating counters and clear");

        $display("%0d tests passed, %0d tests failed, %0d errors",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("TEST PASSED");
        end else begin
            $display("TEST FAILED");
        end
        $finish;
    end

endmodule

// File: test/window_monitor_model.sv
// cycle model of the window monitor, the testbench compares every DUT output against it
module monitor_model (
    input  logic                         clk,
    input  logic                         rst_n,
    input  window_types_pkg::sample_t    data_in,
    input  window_types_pkg::sample_t    win_low,
    input  window_types_pkg::sample_t    win_high,
    input  window_types_pkg::dwell_t     dwell_len,
    input  logic                         count_clear,
    output logic                         exp_event,
    output monitor_ctrl_pkg::cross_dir_t exp_dir,
    output window_types_pkg::side_t      exp_side,
    output logic                         exp_outside,
    output window_types_pkg::count_t     exp_exit_count,
    output window_types_pkg::count_t     exp_entry_count
);
    timeunit 1ns;
    timeprecision 1ps;

    // classification of the last three captured samples, index 2 is the oldest
    logic                             class_out  [3];
    window_types_pkg::side_t          class_side [3];
    monitor_ctrl_pkg::monitor_state_t state;
    // disagreeing samples seen so far in the current run
    int                               run_len;
    logic                             settled_out;
    logic                             below;
    logic                             above;

    always @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            class_out  = '{1'b0, 1'b0, 1'b0};
            class_side = '{window_types_pkg::side_low, window_types_pkg::side_low,
                           window_types_pkg::side_low};
            state           = monitor_ctrl_pkg::st_inside;
            run_len         = 0;
            exp_event       = 1'b0;
            exp_dir         = monitor_ctrl_pkg::dir_exit;
            exp_side        = window_types_pkg::side_low;
            exp_outside     = 1'b0;
            exp_exit_count  = '0;
            exp_entry_count = '0;
        end else begin
            // counts follow the event of the previous cycle
            if (count_clear) begin
                exp_exit_count  = '0;
                exp_entry_count = '0;
            end else if (exp_event && exp_dir == monitor_ctrl_pkg::dir_exit) begin
                if (exp_exit_count != '1) begin
                    exp_exit_count = exp_exit_count + 1'b1;
                end
            end else if (exp_event && exp_entry_count != '1) begin
                exp_entry_count = exp_entry_count + 1'b1;
            end

            // filter sees a sample three edges after it was captured
            settled_out = (state == monitor_ctrl_pkg::st_outside) ||
                          (state == monitor_ctrl_pkg::st_entering);
            exp_event = 1'b0;
            if (class_out[2] == settled_out) begin
                run_len = 0;
                state   = settled_out ? monitor_ctrl_pkg::st_outside : monitor_ctrl_pkg::st_inside;
            end else begin
                run_len = run_len + 1;
                state   = settled_out ? monitor_ctrl_pkg::st_entering : monitor_ctrl_pkg::st_exiting;
                // dwell_len + 1 agreeing samples accept the change
                if (run_len > dwell_len) begin
                    run_len   = 0;
                    exp_event = 1'b1;
                    if (settled_out) begin
                        state   = monitor_ctrl_pkg::st_inside;
                        exp_dir = monitor_ctrl_pkg::dir_entry;
                    end else begin
                        state    = monitor_ctrl_pkg::st_outside;
                        exp_dir  = monitor_ctrl_pkg::dir_exit;
                        exp_side = class_side[2];
                    end
                end
            end
            exp_outside = (state == monitor_ctrl_pkg::st_outside) ||
                          (state == monitor_ctrl_pkg::st_entering);

            class_out[2]  = class_out[1];
            class_out[1]  = class_out[0];
            class_side[2] = class_side[1];
            class_side[1] = class_side[0];
            below = data_in < win_low;
            above = data_in > win_high;
            class_out[0]  = below || above;
            class_side[0] = below ? window_types_pkg::side_low : window_types_pkg::side_high;
        end
    end

endmodule

// File: logic/window_monitor.sv
// top level of the window monitor, connects compare pipeline, dwell filter and counters
module window_monitor (
    input  logic                         clk,
    input  logic                         rst_n,
    input  window_types_pkg::sample_t    data_in,
    input  window_types_pkg::sample_t    win_low,
    input  window_types_pkg::sample_t    win_high,
    input  window_types_pkg::dwell_t     dwell_len,
    input  logic                         count_clear,
    output logic                         cross_event,
    output monitor_ctrl_pkg::cross_dir_t cross_dir,
    output window_types_pkg::side_t      cross_side,
    output logic                         outside,
    output window_types_pkg::count_t     exit_count,
    output window_types_pkg::count_t     entry_count
);

    logic                    outside_flag;
    window_types_pkg::side_t side_flag;
    logic                    dwell_run;
    logic                    dwell_done;

    window_compare window_compare_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .data_in      (data_in),
        .win_low      (win_low),
        .win_high     (win_high),
        .outside_flag (outside_flag),
        .side_flag    (side_flag)
    );

    dwell_timer dwell_timer_i (
        .clk        (clk),
        .rst_n      (rst_n),
        .dwell_run  (dwell_run),
        .dwell_len  (dwell_len),
        .dwell_done (dwell_done)
    );

    crossing_fsm crossing_fsm_i (
        .clk          (clk),
        .rst_n        (rst_n),
        .outside_flag (outside_flag),
        .side_flag    (side_flag),
        .dwell_done   (dwell_done),
        .dwell_run    (dwell_run),
        .cross_event  (cross_event),
        .cross_dir    (cross_dir),
        .cross_side   (cross_side),
        .outside      (outside)
    );

    // counts lag the event pulse by one cycle
    event_counter event_counter_i (
        .clk         (clk),
        .rst_n       (rst_n),
        .cross_event (cross_event),
        .cross_dir   (cross_dir),
        .count_clear (count_clear),
        .exit_count  (exit_count),
        .entry_count (entry_count)
    );

endmodule

// File: logic/event_counter.sv
// saturating exit and entry counters driven by crossing events, cleared by a pulse
module event_counter (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         cross_event,
    input  monitor_ctrl_pkg::cross_dir_t cross_dir,
    input  logic                         count_clear,
    output window_types_pkg::count_t     exit_count,
    output window_types_pkg::count_t     entry_count
);

    // holds at all ones instead of wrapping
    function automatic window_types_pkg::count_t sat_inc(
        input window_types_pkg::count_t value
    );
        window_types_pkg::count_t result;
        if (value == '1) begin
            result = value;
        end else begin
            result = value + 1'b1;
        end
        return result;
    endfunction

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            exit_count  <= '0;
            entry_count <= '0;
        end else if (count_clear) begin
            // clear beats a same-cycle event
            exit_count  <= '0;
            entry_count <= '0;
        end else if (cross_event) begin
            if (cross_dir == monitor_ctrl_pkg::dir_exit) begin
                exit_count <= sat_inc(exit_count);
            end else begin
                entry_count <= sat_inc(entry_count);
            end
        end
    end

endmodule

// File: logic/crossing_fsm.sv
// dwell filter FSM that accepts exits and entries and registers the crossing event outputs
module crossing_fsm (
    input  logic                         clk,
    input  logic                         rst_n,
    input  logic                         outside_flag,
    input  window_types_pkg::side_t      side_flag,
    input  logic                         dwell_done,
    output logic                         dwell_run,
    output logic                         cross_event,
    output monitor_ctrl_pkg::cross_dir_t cross_dir,
    output window_types_pkg::side_t      cross_side,
    output logic                         outside
);

    monitor_ctrl_pkg::monitor_state_t state;
    monitor_ctrl_pkg::monitor_state_t state_next;
    logic                             exit_hit;
    logic                             entry_hit;

    // settled side of the window, pending states keep the old one
    assign outside = (state == monitor_ctrl_pkg::st_outside) ||
                     (state == monitor_ctrl_pkg::st_entering);

    // any sample that disagrees with the settled state extends the run
    assign dwell_run = outside_flag != outside;

    always_comb begin
        state_next = state;
        exit_hit   = 1'b0;
        entry_hit  = 1'b0;
        case (state)
            monitor_ctrl_pkg::st_inside: begin
                if (outside_flag) begin
                    if (dwell_done) begin
                        state_next = monitor_ctrl_pkg::st_outside;
                        exit_hit   = 1'b1;
                    end else begin
                        state_next = monitor_ctrl_pkg::st_exiting;
                    end
                end
            end
            monitor_ctrl_pkg::st_exiting: begin
                if (!outside_flag) begin
                    state_next = monitor_ctrl_pkg::st_inside;
                end else if (dwell_done) begin
                    state_next = monitor_ctrl_pkg::st_outside;
                    exit_hit   = 1'b1;
                end
            end
            monitor_ctrl_pkg::st_outside: begin
                if (!outside_flag) begin
                    if (dwell_done) begin
                        state_next = monitor_ctrl_pkg::st_inside;
                        entry_hit  = 1'b1;
                    end else begin
                        state_next = monitor_ctrl_pkg::st_entering;
                    end
                end
            end
            monitor_ctrl_pkg::st_entering: begin
                if (outside_flag) begin
                    state_next = monitor_ctrl_pkg::st_outside;
                end else if (dwell_done) begin
                    state_next = monitor_ctrl_pkg::st_inside;
                    entry_hit  = 1'b1;
                end
            end
            default: begin
                state_next = monitor_ctrl_pkg::st_inside;
            end
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state <= monitor_ctrl_pkg::st_inside;
        end else begin
            state <= state_next;
        end
    end

    // exits and entries alternate, so cross_side still holds the last exit side on entry
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            cross_event <= 1'b0;
            cross_dir   <= monitor_ctrl_pkg::dir_exit;
            cross_side  <= window_types_pkg::side_low;
        end else begin
            cross_event <= exit_hit | entry_hit;
            if (exit_hit) begin
                cross_dir  <= monitor_ctrl_pkg::dir_exit;
                cross_side <= side_flag;
            end else if (entry_hit) begin
                cross_dir <= monitor_ctrl_pkg::dir_entry;
            end
        end
    end

endmodule

// File: logic/dwell_timer.sv
// counts consecutive disagreeing samples and flags when the dwell length is reached
module dwell_timer (
    input  logic                     clk,
    input  logic                     rst_n,
    input  logic                     dwell_run,
    input  window_types_pkg::dwell_t dwell_len,
    output logic                     dwell_done
);

    window_types_pkg::dwell_t count;

    // count holds the number of earlier disagreeing samples in this run
    assign dwell_done = dwell_run && (count == dwell_len);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            count <= '0;
        end else if (!dwell_run || dwell_done) begin
            // run broken or change accepted, next run starts from zero
            count <= '0;
        end else begin
            count <= count + 1'b1;
        end
    end

endmodule

// File: logic/window_compare.sv
// three-stage compare pipeline that flags samples below or above their window bounds
module window_compare (
    input  logic                      clk,
    input  logic                      rst_n,
    input  window_types_pkg::sample_t data_in,
    input  window_types_pkg::sample_t win_low,
    input  window_types_pkg::sample_t win_high,
    output logic                      outside_flag,
    output window_types_pkg::side_t   side_flag
);

    // one extra bit holds the borrow of the subtraction
    typedef logic [window_types_pkg::sample_width:0] diff_t;

    window_types_pkg::sample_t data_q;
    window_types_pkg::sample_t low_q;
    window_types_pkg::sample_t high_q;
    diff_t                     diff_low_q;
    diff_t                     diff_high_q;
    logic                      below;
    logic                      above;

    // stage one, capture sample and bounds
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            data_q <= '0;
            low_q  <= '0;
            high_q <= '0;
        end else begin
            data_q <= data_in;
            low_q  <= win_low;
            high_q <= win_high;
        end
    end

    // stage two, zero-extended differences so the top bit is a true borrow
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            diff_low_q  <= '0;
            diff_high_q <= '0;
        end else begin
            diff_low_q  <= {1'b0, data_q} - {1'b0, low_q};
            diff_high_q <= {1'b0, high_q} - {1'b0, data_q};
        end
    end

    // borrow on data - low means data < low
    assign below = diff_low_q[window_types_pkg::sample_width];
    assign above = diff_high_q[window_types_pkg::sample_width];

    // stage three, classification flags
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            outside_flag <= 1'b0;
            side_flag    <= window_types_pkg::side_low;
        end else begin
            outside_flag <= below | above;
            // inverted window can set both, low side wins
            if (below) begin
                side_flag <= window_types_pkg::side_low;
            end else begin
                side_flag <= window_types_pkg::side_high;
            end
        end
    end

endmodule

// File: logic/monitor_ctrl_pkg.sv
// state and crossing direction encodings for the dwell filter and event logic
package monitor_ctrl_pkg;

    // settled states plus one pending state per direction
    typedef enum logic [1:0] {
        st_inside   = 2'd0,
        st_exiting  = 2'd1,
        st_outside  = 2'd2,
        st_entering = 2'd3
    } monitor_state_t;

    // direction of an accepted change
    typedef enum logic {
        dir_exit  = 1'b0,
        dir_entry = 1'b1
    } cross_dir_t;

endpackage

// File: logic/window_types_pkg.sv
// data widths and window side encoding shared by the monitor RTL and its testbench
package window_types_pkg;

    // edit these to resize the datapath
    localparam int sample_width = 8;
    localparam int dwell_width  = 4;
    localparam int count_width  = 8;

    // one sample or one window bound
    typedef logic [sample_width-1:0] sample_t;

    // extra samples a change must persist before it is accepted
    typedef logic [dwell_width-1:0] dwell_t;

    // event count, saturates at all ones
    typedef logic [count_width-1:0] count_t;

    // which bound was crossed, below wins when both are
    typedef enum logic {
        side_low  = 1'b0,
        side_high = 1'b1
    } side_t;

endpackage
